/* verilog.f */
+incdir+include
logic/riscv_pkg.sv
logic/riscv_cu.sv
logic/riscv_regfile.sv
logic/riscv_fetch.sv
logic/riscv_decode.sv
logic/riscv_execute.sv
logic/riscv_memwb.sv
logic/riscv_hazardunit.sv
logic/riscv_core.sv
verif/tb_riscv_core.sv

/* Bender.yml */
package:
  name: riscv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/riscv_pkg.sv
      - logic/riscv_cu.sv
      - logic/riscv_regfile.sv
      - logic/riscv_fetch.sv
      - logic/riscv_decode.sv
      - logic/riscv_execute.sv
      - logic/riscv_memwb.sv
      - logic/riscv_hazardunit.sv
      - logic/riscv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_riscv_core.sv

/* verif/tb_riscv_core.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module tb_riscv_core;

  localparam int          PROG_LEN = 24;
  localparam logic [31:0] NOP      = 32'h0000_0013;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] data;
  } store_t;

  logic             clk = 1'b0;
  logic             rst_n;
  logic [31:0]      inst;
  logic [`XLEN-1:0] rdata;
  logic             stall_dm;
  logic [`XLEN-1:0] pc;
  logic             memr;
  logic             memw;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] wdata;
  logic             globstall;

  logic [31:0]      rom [64];
  logic [`XLEN-1:0] dmem [64];
  store_t           exp_q [$];
  store_t           exp_st;
  int               loads_exp  = 0;
  int               loads_seen = 0;
  int               val_errs   = 0;
  int               proto_errs = 0;
  int               left       = 0;                  // Stall cycles still owed to this access
  logic             drawn      = 1'b0;
  int               cycles;

  riscv_core dut_i (
    .i_riscv_core_clk           (clk),
    .i_rst_n                    (rst_n),
    .i_riscv_core_inst          (inst),
    .i_riscv_core_rdata         (rdata),
    .i_riscv_core_stall_dm      (stall_dm),
    .o_riscv_core_pc            (pc),
    .o_riscv_core_memr_e        (memr),
    .o_riscv_core_memw_e        (memw),
    .o_riscv_core_memodata_addr (addr),
    .o_riscv_core_storedata_m   (wdata),
    .o_riscv_core_globstall     (globstall)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, `F3_ADD, rd, `OP_ITYPE};
  endfunction

  function automatic logic [31:0] ld(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, `F3_LD, rd, `OP_LOAD};
  endfunction

  function automatic logic [31:0] sd(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, `F3_LD, imm[4:0], `OP_STORE};
  endfunction

  function automatic logic [31:0] beq(input logic [4:0] rs1, rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, `F3_BEQ, off[4:1], off[11], `OP_BRANCH};
  endfunction

  function automatic logic [`XLEN-1:0] fill_word(input logic [5:0] idx);
    return {32'hc0de_0000 ^ {26'd0, idx}, ~({26'd0, idx} * 32'h0101_0101)};
  endfunction

  function automatic logic [31:0] rom_word(input logic [`XLEN-1:0] fetch_pc);
    return (fetch_pc < 64'd256) ? rom[fetch_pc[7:2]] : NOP;   // NOPs past the program
  endfunction

  // Runs the program one instruction at a time to get the stores the bus must show
  task automatic build_expected();
    logic [`XLEN-1:0]  x [32];
    logic [`XLEN-1:0]  m [64];
    logic [31:0]       w;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
    logic [`XLEN-1:0]  ea;
    logic signed [12:0] boff;
    int                idx;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 64; i++) m[i] = fill_word(i[5:0]);
    idx = 0;
    while (idx < PROG_LEN) begin
      w    = rom[idx];
      a    = x[w[19:15]];
      b    = x[w[24:20]];
      boff = {w[31], w[7], w[30:25], w[11:8], 1'b0};
      idx++;
      case (w[6:0])
        `OP_RTYPE: begin
          case ({w[31:25], w[14:12]})
            {7'd0, `F3_ADD}:    x[w[11:7]] = a + b;
            {`F7_SUB, `F3_ADD}: x[w[11:7]] = a - b;
            {7'd0, `F3_XOR}:    x[w[11:7]] = a ^ b;
            {7'd0, `F3_OR}:     x[w[11:7]] = a | b;
            {7'd0, `F3_AND}:    x[w[11:7]] = a & b;
            default: ;
          endcase
        end
        `OP_ITYPE: x[w[11:7]] = a + {{52{w[31]}}, w[31:20]};
        `OP_LOAD: begin
          ea         = a + {{52{w[31]}}, w[31:20]};
          x[w[11:7]] = m[ea[8:3]];
          loads_exp++;
        end
        `OP_STORE: begin
          ea         = a + {{52{w[31]}}, w[31:25], w[11:7]};
          m[ea[8:3]] = b;
          exp_q.push_back({ea, b});
        end
        `OP_BRANCH: if (a == b) idx = idx - 1 + (boff >>> 2);
        default: ;
      endcase
      x[0] = '0;
    end
  endtask

  // Completes accesses at the edge, then drives fetch, load data and back-pressure
  always @(posedge clk) begin
    if (rst_n && (memr || memw) && !stall_dm) begin
      if (memw) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("Store to address %h arrived after all expected stores", addr);
        end else begin
          exp_st = exp_q.pop_front();
          chk_store: assert (addr == exp_st.addr && wdata == exp_st.data) else begin
            val_errs++;
            $display("** Error at %0t: store %h <- %h, expected %h <- %h",
                     $time, addr, wdata, exp_st.addr, exp_st.data);
          end
        end
        dmem[addr[8:3]] = wdata;
      end else begin
        loads_seen++;
      end
      drawn = 1'b0;
    end
    #2;
    inst  = rom_word(pc);
    rdata = dmem[addr[8:3]];
    if (rst_n && (memr || memw) && !drawn) begin
      left  = $urandom % 4;                             // New access gets 0 to 3 stall cycles
      drawn = 1'b1;
    end
    stall_dm = (left != 0);
    if (left != 0) left--;
  end

  a_reset_state: assert property (@(posedge clk)
    !rst_n |-> (pc == `RESET_PC && !memr && !memw && !globstall))
    else begin
      val_errs++;
      $display("** Error at %0t: outputs left their reset values during reset", $time);
    end

  a_globstall: assert property (@(posedge clk) disable iff (!rst_n) globstall == stall_dm)
    else begin
      val_errs++;
      $display("** Error at %0t: globstall %b with memory stall %b", $time, globstall, stall_dm);
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall_dm |=> $stable(pc) && $stable(addr) && $stable(wdata) && $stable(memr) && $stable(memw))
    else begin
      val_errs++;
      $display("** Error at %0t: PC or memory request moved during a stall", $time);
    end

  initial begin
    rst_n    = 1'b1;
    inst     = NOP;
    rdata    = '0;
    stall_dm = 1'b0;
    void'($urandom(32'h1ee0));
    for (int i = 0; i < 64; i++) begin
      rom[i]  = NOP;
      dmem[i] = fill_word(i[5:0]);
    end
    rom[0]  = addi(1, 0, 100);
    rom[1]  = addi(2, 1, 23);
    rom[2]  = alu_rr(7'd0, `F3_ADD, 3, 1, 2);
    rom[3]  = alu_rr(`F7_SUB, `F3_ADD, 4, 3, 1);
    rom[4]  = alu_rr(7'd0, `F3_XOR, 5, 4, 3);
    rom[5]  = alu_rr(7'd0, `F3_OR, 6, 5, 1);
    rom[6]  = alu_rr(7'd0, `F3_AND, 7, 6, 3);
    rom[7]  = sd(7, 0, 0);
    rom[8]  = sd(3, 0, 8);
    rom[9]  = sd(6, 0, 16);
    rom[10] = ld(8, 0, 64);
    rom[11] = alu_rr(7'd0, `F3_ADD, 9, 1, 8);            // Load-use on rs2
    rom[12] = sd(9, 0, 24);
    rom[13] = addi(0, 0, 55);
    rom[14] = sd(0, 0, 32);
    rom[15] = ld(10, 0, 0);
    rom[16] = alu_rr(7'd0, `F3_ADD, 11, 10, 10);
    rom[17] = sd(11, 0, 40);
    rom[18] = beq(1, 1, 13'd12);                         // Taken, skips the next two stores
    rom[19] = sd(1, 0, 48);
    rom[20] = sd(2, 0, 56);
    rom[21] = sd(4, 0, 48);
    rom[22] = beq(1, 2, 13'd8);
    rom[23] = sd(3, 0, 56);
    build_expected();
    #1 rst_n = 1'b0;                                   // Falling edge after time zero reaches every flop
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      proto_errs++;
      $display("Timeout with %0d expected stores never seen on the bus", exp_q.size());
    end
    repeat (10) @(posedge clk);
    if (loads_seen != loads_exp) begin
      proto_errs++;
      $display("Saw %0d completed loads where the program has %0d", loads_seen, loads_exp);
    end
    $display("Errors: %0d wrong values, %0d other failures", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* logic/riscv_core.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_core import riscv_pkg::*; (
  input  logic             i_riscv_core_clk,
  input  logic             i_rst_n,
  input  logic [31:0]      i_riscv_core_inst,
  input  logic [`XLEN-1:0] i_riscv_core_rdata,
  input  logic             i_riscv_core_stall_dm,
  output logic [`XLEN-1:0] o_riscv_core_pc,
  output logic             o_riscv_core_memr_e,
  output logic             o_riscv_core_memw_e,
  output logic [`XLEN-1:0] o_riscv_core_memodata_addr,
  output logic [`XLEN-1:0] o_riscv_core_storedata_m,
  output logic             o_riscv_core_globstall
);

  logic [`XLEN-1:0]      pc_d;
  logic [31:0]           inst_d;
  ctrl_t                 ctrl_d;
  logic [`RF_ADDR_W-1:0] rs1_d;
  logic [`RF_ADDR_W-1:0] rs2_d;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  de_t                   de;
  em_t                   em;
  mw_t                   wb;
  logic [`XLEN-1:0]      em_fwd;
  logic [`XLEN-1:0]      branch_target;
  logic                  pcsrc;
  fwd_sel_e              fwd_a;
  fwd_sel_e              fwd_b;
  logic                  stall_pc;
  logic                  stall_fd;
  logic                  flush_fd;
  logic                  stall_de;
  logic                  flush_de;
  logic                  stall_em;
  logic                  stall_mw;

  riscv_fetch u_fetch (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_stall_pc       (stall_pc),
    .i_stall_fd       (stall_fd),
    .i_flush_fd       (flush_fd),
    .i_pcsrc          (pcsrc),
    .i_branch_target  (branch_target),
    .i_inst           (i_riscv_core_inst),
    .o_pc             (o_riscv_core_pc),
    .o_pc_d           (pc_d),
    .o_inst_d         (inst_d)
  );

  riscv_cu u_cu (
    .i_inst (inst_d),
    .o_ctrl (ctrl_d)
  );

  riscv_regfile u_regfile (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_rs1            (rs1_d),
    .i_rs2            (rs2_d),
    .i_wb             (wb),
    .o_rs1_data       (rs1_data),
    .o_rs2_data       (rs2_data)
  );

  riscv_decode u_decode (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_inst           (inst_d),
    .i_pc             (pc_d),
    .i_ctrl           (ctrl_d),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .i_stall_de       (stall_de),
    .i_flush_de       (flush_de),
    .o_rs1            (rs1_d),
    .o_rs2            (rs2_d),
    .o_de             (de)
  );

  riscv_execute u_execute (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_de             (de),
    .i_fwd_a          (fwd_a),
    .i_fwd_b          (fwd_b),
    .i_em_fwd         (em_fwd),
    .i_wb             (wb),
    .i_stall_em       (stall_em),
    .o_em             (em),
    .o_pcsrc          (pcsrc),
    .o_branch_target  (branch_target)
  );

  riscv_memwb u_memwb (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_em             (em),
    .i_rdata          (i_riscv_core_rdata),
    .i_stall_mw       (stall_mw),
    .o_memr           (o_riscv_core_memr_e),
    .o_memw           (o_riscv_core_memw_e),
    .o_addr           (o_riscv_core_memodata_addr),
    .o_wdata          (o_riscv_core_storedata_m),
    .o_wb             (wb),
    .o_em_fwd         (em_fwd)
  );

  // A load-use hazard exists when the execute result comes from memory
  riscv_hazardunit u_hazardunit (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_rs1_d          (rs1_d),
    .i_rs2_d          (rs2_d),
    .i_rs1_e          (de.rs1),
    .i_rs2_e          (de.rs2),
    .i_rd_e           (de.rd),
    .i_memr_e         (de.ctrl.result_from_mem),
    .i_pcsrc          (pcsrc),
    .i_em             (em),
    .i_wb             (wb),
    .i_stall_dm       (i_riscv_core_stall_dm),
    .o_fwd_a          (fwd_a),
    .o_fwd_b          (fwd_b),
    .o_stall_pc       (stall_pc),
    .o_stall_fd       (stall_fd),
    .o_flush_fd       (flush_fd),
    .o_stall_de       (stall_de),
    .o_flush_de       (flush_de),
    .o_stall_em       (stall_em),
    .o_stall_mw       (stall_mw),
    .o_globstall      (o_riscv_core_globstall)
  );

endmodule

/* logic/riscv_hazardunit.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_hazardunit import riscv_pkg::*; (
  input  logic                  i_riscv_core_clk,
  input  logic                  i_rst_n,
  input  logic [`RF_ADDR_W-1:0] i_rs1_d,
  input  logic [`RF_ADDR_W-1:0] i_rs2_d,
  input  logic [`RF_ADDR_W-1:0] i_rs1_e,
  input  logic [`RF_ADDR_W-1:0] i_rs2_e,
  input  logic [`RF_ADDR_W-1:0] i_rd_e,
  input  logic                  i_memr_e,
  input  logic                  i_pcsrc,
  input  em_t                   i_em,
  input  mw_t                   i_wb,
  input  logic                  i_stall_dm,
  output fwd_sel_e              o_fwd_a,
  output fwd_sel_e              o_fwd_b,
  output logic                  o_stall_pc,
  output logic                  o_stall_fd,
  output logic                  o_flush_fd,
  output logic                  o_stall_de,
  output logic                  o_flush_de,
  output logic                  o_stall_em,
  output logic                  o_stall_mw,
  output logic                  o_globstall
);

  logic load_use;

  // The memory stage holds the younger result, so it wins over writeback
  function automatic fwd_sel_e fwd_sel(input logic [`RF_ADDR_W-1:0] src, input em_t em,
                                       input mw_t wb);
    fwd_sel_e sel;
    if (src != '0 && em.regw && em.rd == src)
      sel = FWD_MEM;
    else if (src != '0 && wb.regw && wb.rd == src)
      sel = FWD_WB;
    else
      sel = FWD_RF;
    return sel;
  endfunction

  assign o_fwd_a = fwd_sel(i_rs1_e, i_em, i_wb);
  assign o_fwd_b = fwd_sel(i_rs2_e, i_em, i_wb);

  assign load_use = i_memr_e && i_rd_e != '0 && (i_rd_e == i_rs1_d || i_rd_e == i_rs2_d);

  assign o_globstall = i_stall_dm;
  assign o_stall_pc  = load_use | i_stall_dm;
  assign o_stall_fd  = load_use | i_stall_dm;
  assign o_flush_fd  = i_pcsrc & ~i_stall_dm;
  assign o_stall_de  = i_stall_dm;
  assign o_flush_de  = (load_use | i_pcsrc) & ~i_stall_dm;  // Bubble into execute
  assign o_stall_em  = i_stall_dm;
  assign o_stall_mw  = i_stall_dm;

  a_no_flush_stall: assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    !(o_flush_fd && o_stall_fd) && !(o_flush_de && o_stall_de));

endmodule

/* logic/riscv_memwb.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_memwb import riscv_pkg::*; (
  input  logic             i_riscv_core_clk,
  input  logic             i_rst_n,
  input  em_t              i_em,
  input  logic [`XLEN-1:0] i_rdata,
  input  logic             i_stall_mw,
  output logic             o_memr,
  output logic             o_memw,
  output logic [`XLEN-1:0] o_addr,
  output logic [`XLEN-1:0] o_wdata,
  output mw_t              o_wb,
  output logic [`XLEN-1:0] o_em_fwd
);

  // Port requests come straight from the register, so they hold during a stall
  assign o_memr   = i_em.memr;
  assign o_memw   = i_em.memw;
  assign o_addr   = i_em.alu_result;
  assign o_wdata  = i_em.store_data;
  assign o_em_fwd = i_em.alu_result;

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb <= '0;
    end else if (!i_stall_mw) begin                    // Load data is only valid once the stall ends
      o_wb.regw <= i_em.regw;
      o_wb.data <= i_em.memr ? i_rdata : i_em.alu_result;
      o_wb.rd   <= i_em.rd;
    end
  end

  a_one_access: assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    !(o_memr && o_memw));

endmodule

/* logic/riscv_execute.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_execute import riscv_pkg::*; (
  input  logic             i_riscv_core_clk,
  input  logic             i_rst_n,
  input  de_t              i_de,
  input  fwd_sel_e         i_fwd_a,
  input  fwd_sel_e         i_fwd_b,
  input  logic [`XLEN-1:0] i_em_fwd,
  input  mw_t              i_wb,
  input  logic             i_stall_em,
  output em_t              o_em,
  output logic             o_pcsrc,
  output logic [`XLEN-1:0] o_branch_target
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;

  always_comb begin
    case (i_fwd_a)
      FWD_MEM: op_a = i_em_fwd;
      FWD_WB:  op_a = i_wb.data;
      default: op_a = i_de.rs1_data;
    endcase
    case (i_fwd_b)
      FWD_MEM: rs2_val = i_em_fwd;
      FWD_WB:  rs2_val = i_wb.data;
      default: rs2_val = i_de.rs2_data;
    endcase
  end

  assign op_b = i_de.ctrl.imm_sel ? i_de.imm : rs2_val;

  always_comb begin
    case (i_de.ctrl.alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      default: alu_result = op_a + op_b;
    endcase
  end

  // BEQ resolves here, the PC takes the target at the next edge
  assign o_pcsrc         = i_de.valid && i_de.ctrl.branch && (op_a == rs2_val);
  assign o_branch_target = i_de.pc + i_de.imm;

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_em <= '0;
    end else if (!i_stall_em) begin
      o_em.regw       <= i_de.valid & i_de.ctrl.regw;
      o_em.memr       <= i_de.valid & i_de.ctrl.memr;
      o_em.memw       <= i_de.valid & i_de.ctrl.memw;
      o_em.alu_result <= alu_result;
      o_em.store_data <= rs2_val;                      // Forwarded, so SD right after a producer works
      o_em.rd         <= i_de.rd;
    end
  end

endmodule

/* logic/riscv_decode.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_decode import riscv_pkg::*; (
  input  logic                  i_riscv_core_clk,
  input  logic                  i_rst_n,
  input  logic [31:0]           i_inst,
  input  logic [`XLEN-1:0]      i_pc,
  input  ctrl_t                 i_ctrl,
  input  logic [`XLEN-1:0]      i_rs1_data,
  input  logic [`XLEN-1:0]      i_rs2_data,
  input  logic                  i_stall_de,
  input  logic                  i_flush_de,
  output logic [`RF_ADDR_W-1:0] o_rs1,
  output logic [`RF_ADDR_W-1:0] o_rs2,
  output de_t                   o_de
);

  logic [`XLEN-1:0] imm;

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  always_comb begin
    case (i_inst[6:0])
      `OP_ITYPE, `OP_LOAD:
        imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
      `OP_STORE:
        imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      `OP_BRANCH:                                       // Byte offset, bit 0 always clear
        imm = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
               i_inst[11:8], 1'b0};
      default:
        imm = '0;
    endcase
  end

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_de <= '0;
    end else if (i_flush_de) begin                     // Bubble with all control cleared
      o_de <= '0;
    end else if (!i_stall_de) begin
      o_de.ctrl     <= i_ctrl;
      o_de.pc       <= i_pc;
      o_de.rs1_data <= i_rs1_data;
      o_de.rs2_data <= i_rs2_data;
      o_de.imm      <= imm;
      o_de.rs1      <= o_rs1;
      o_de.rs2      <= o_rs2;
      o_de.rd       <= i_inst[11:7];
      o_de.valid    <= 1'b1;
    end
  end

endmodule

/* logic/riscv_fetch.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_fetch (
  input  logic             i_riscv_core_clk,
  input  logic             i_rst_n,
  input  logic             i_stall_pc,
  input  logic             i_stall_fd,
  input  logic             i_flush_fd,
  input  logic             i_pcsrc,
  input  logic [`XLEN-1:0] i_branch_target,
  input  logic [31:0]      i_inst,
  output logic [`XLEN-1:0] o_pc,
  output logic [`XLEN-1:0] o_pc_d,
  output logic [31:0]      o_inst_d
);

  localparam logic [31:0] nop_inst = 32'h0000_0013;   // addi x0, x0, 0

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_pc <= `RESET_PC;
    else if (!i_stall_pc)
      o_pc <= i_pcsrc ? i_branch_target : o_pc + `XLEN'd4;
  end

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc_d   <= '0;
      o_inst_d <= nop_inst;
    end else if (i_flush_fd) begin                     // Wrong-path fetch after a taken BEQ
      o_pc_d   <= '0;
      o_inst_d <= nop_inst;
    end else if (!i_stall_fd) begin
      o_pc_d   <= o_pc;
      o_inst_d <= i_inst;
    end
  end

endmodule

/* logic/riscv_regfile.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_regfile import riscv_pkg::*; (
  input  logic                  i_riscv_core_clk,
  input  logic                  i_rst_n,
  input  logic [`RF_ADDR_W-1:0] i_rs1,
  input  logic [`RF_ADDR_W-1:0] i_rs2,
  input  mw_t                   i_wb,
  output logic [`XLEN-1:0]      o_rs1_data,
  output logic [`XLEN-1:0]      o_rs2_data
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge i_riscv_core_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      regs <= '{default: '0};
    end else if (i_wb.regw && i_wb.rd != '0) begin     // x0 is never written
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // Writes in the same cycle pass straight through to decode
  assign o_rs1_data = (i_rs1 == '0) ? '0 :
                      (i_wb.regw && i_wb.rd == i_rs1) ? i_wb.data : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 :
                      (i_wb.regw && i_wb.rd == i_rs2) ? i_wb.data : regs[i_rs2];

  a_x0_zero: assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    regs[0] == '0);

endmodule

/* logic/riscv_cu.sv */
`timescale 1ns/10ps
`include "riscv_params.svh"

module riscv_cu import riscv_pkg::*; (
  input  logic [31:0] i_inst,
  output ctrl_t       o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    o_ctrl = '0;                                        // Anything unknown runs as a NOP
    case (opcode)
      `OP_RTYPE: begin
        o_ctrl.regw = 1'b1;
        if (funct3 == `F3_ADD && funct7 == `F7_SUB)
          o_ctrl.alu_op = ALU_SUB;
        else if (funct7 != 7'd0)
          o_ctrl.regw = 1'b0;
        else if (funct3 == `F3_ADD)
          o_ctrl.alu_op = ALU_ADD;
        else if (funct3 == `F3_XOR)
          o_ctrl.alu_op = ALU_XOR;
        else if (funct3 == `F3_OR)
          o_ctrl.alu_op = ALU_OR;
        else if (funct3 == `F3_AND)
          o_ctrl.alu_op = ALU_AND;
        else
          o_ctrl.regw = 1'b0;
      end
      `OP_ITYPE: begin
        o_ctrl.regw    = (funct3 == `F3_ADD);
        o_ctrl.imm_sel = 1'b1;
      end
      `OP_LOAD: begin
        o_ctrl.regw            = (funct3 == `F3_LD);
        o_ctrl.memr            = (funct3 == `F3_LD);
        o_ctrl.result_from_mem = (funct3 == `F3_LD);
        o_ctrl.imm_sel         = 1'b1;
      end
      `OP_STORE: begin
        o_ctrl.memw    = (funct3 == `F3_LD);            // SD shares the doubleword funct3
        o_ctrl.imm_sel = 1'b1;
      end
      `OP_BRANCH: begin
        o_ctrl.branch = (funct3 == `F3_BEQ);
        o_ctrl.alu_op = ALU_SUB;
      end
      default: o_ctrl = '0;
    endcase
  end

endmodule

/* logic/riscv_pkg.sv */
`include "riscv_params.svh"

package riscv_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_RF,                          // Operand read in decode
    FWD_MEM,                         // ALU result of the memory stage
    FWD_WB                           // Result in the writeback stage
  } fwd_sel_e;

  typedef struct packed {
    logic    regw;
    logic    memr;
    logic    memw;
    logic    branch;
    logic    imm_sel;                // ALU operand B is the immediate
    logic    result_from_mem;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic [`XLEN-1:0]      imm;
    logic [`RF_ADDR_W-1:0] rs1;
    logic [`RF_ADDR_W-1:0] rs2;
    logic [`RF_ADDR_W-1:0] rd;
    logic                  valid;
  } de_t;

  typedef struct packed {
    logic                  regw;
    logic                  memr;
    logic                  memw;
    logic [`XLEN-1:0]      alu_result;
    logic [`XLEN-1:0]      store_data;
    logic [`RF_ADDR_W-1:0] rd;
  } em_t;

  typedef struct packed {
    logic                  regw;
    logic [`XLEN-1:0]      data;
    logic [`RF_ADDR_W-1:0] rd;
  } mw_t;

endpackage

/* include/riscv_params.svh */
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

`define XLEN       64
`define RF_ADDR_W  5
`define RESET_PC   64'h0

`define OP_RTYPE   7'b0110011
`define OP_ITYPE   7'b0010011
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_BRANCH  7'b1100011

`define F3_ADD     3'b000
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_LD      3'b011
`define F3_BEQ     3'b000

`define F7_SUB     7'b0100000

`endif
